// ==== hw/board_pkg.sv ====
`default_nettype none

package board_pkg;

    typedef logic [31:0] irq_code_t;
    typedef logic [23:0] board_word_t;
    typedef logic [7:0]  scan_code_t;
    // fire bit above a 2-bit direction
    typedef logic [2:0]  key_event_t;
    // active low with bit 6 as segment g
    typedef logic [6:0]  seg_t;

    // serial bit timing
    localparam int CLKS_PER_BIT = 16;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

    localparam scan_code_t SCAN_UP    = 8'h1D;
    localparam scan_code_t SCAN_DOWN  = 8'h1B;
    localparam scan_code_t SCAN_LEFT  = 8'h1C;
    localparam scan_code_t SCAN_RIGHT = 8'h23;
    localparam scan_code_t SCAN_FIRE  = 8'h29;
    localparam scan_code_t SCAN_BREAK = 8'hF0;

    // direction field of key_event_t
    localparam logic [1:0] DIR_UP    = 2'd0;
    localparam logic [1:0] DIR_DOWN  = 2'd1;
    localparam logic [1:0] DIR_LEFT  = 2'd2;
    localparam logic [1:0] DIR_RIGHT = 2'd3;

    localparam irq_code_t IRQ_LEFT  = 32'd102;
    localparam irq_code_t IRQ_UP    = 32'd103;
    localparam irq_code_t IRQ_DOWN  = 32'd104;
    localparam irq_code_t IRQ_RIGHT = 32'd105;
    localparam irq_code_t IRQ_FIRE  = 32'd106;

    // hex digits 0 to F
    localparam seg_t SEG_PATTERNS [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    typedef enum logic [2:0] {
        PS2_IDLE,
        PS2_DATA,
        PS2_PARITY,
        PS2_STOP,
        PS2_DECODE
    } ps2_state_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

`default_nettype wire

// ==== hw/ps2_key_decoder.sv ====
`default_nettype none

module ps2_key_decoder import board_pkg::*; (
    input  wire logic  sys_clk,
    input  wire logic  rst_n,
    input  wire logic  ps2_clk,
    input  wire logic  ps2_dat,
    output logic       key_valid,
    output key_event_t key_event
);

    logic       clk_meta, clk_sync, clk_prev;
    logic       dat_meta, dat_sync;
    logic       ps2_fall;
    ps2_state_t state;
    logic [2:0] bit_cnt;
    logic       break_seen;
    scan_code_t shift_reg;
    logic       parity_bit;
    logic       frame_ok;
    logic       known;
    key_event_t decoded;

    assign ps2_fall = clk_prev & ~clk_sync;
    // odd parity over data and parity bit
    assign frame_ok = ^{shift_reg, parity_bit};

    // make code to fire/direction
    always_comb begin
        known   = 1'b1;
        decoded = {1'b0, DIR_UP};
        case (shift_reg)
            SCAN_UP:    decoded = {1'b0, DIR_UP};
            SCAN_DOWN:  decoded = {1'b0, DIR_DOWN};
            SCAN_LEFT:  decoded = {1'b0, DIR_LEFT};
            SCAN_RIGHT: decoded = {1'b0, DIR_RIGHT};
            SCAN_FIRE:  decoded = {1'b1, DIR_UP};
            default:    known = 1'b0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            clk_meta   <= 1'b1;
            clk_sync   <= 1'b1;
            clk_prev   <= 1'b1;
            dat_meta   <= 1'b1;
            dat_sync   <= 1'b1;
            state      <= PS2_IDLE;
            bit_cnt    <= '0;
            break_seen <= 1'b0;
            key_valid  <= 1'b0;
        end else begin
            clk_meta  <= ps2_clk;
            clk_sync  <= clk_meta;
            clk_prev  <= clk_sync;
            dat_meta  <= ps2_dat;
            dat_sync  <= dat_meta;
            key_valid <= 1'b0;
            case (state)
                PS2_IDLE: begin
                    // start bit is a 0
                    if (ps2_fall && !dat_sync) begin
                        state   <= PS2_DATA;
                        bit_cnt <= '0;
                    end
                end
                PS2_DATA: begin
                    if (ps2_fall) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PS2_PARITY;
                        end
                    end
                end
                PS2_PARITY: begin
                    if (ps2_fall) begin
                        state <= PS2_STOP;
                    end
                end
                PS2_STOP: begin
                    if (ps2_fall) begin
                        state <= (dat_sync && frame_ok) ? PS2_DECODE : PS2_IDLE;
                    end
                end
                PS2_DECODE: begin
                    state <= PS2_IDLE;
                    // byte after F0 is the released key
                    if (break_seen) begin
                        break_seen <= 1'b0;
                    end else if (shift_reg == SCAN_BREAK) begin
                        break_seen <= 1'b1;
                    end else begin
                        key_valid <= known;
                    end
                end
                default: state <= PS2_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        // lsb first
        if (ps2_fall && state == PS2_DATA) begin
            shift_reg <= {dat_sync, shift_reg[7:1]};
        end
        if (ps2_fall && state == PS2_PARITY) begin
            parity_bit <= dat_sync;
        end
        if (state == PS2_DECODE) begin
            key_event <= decoded;
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_word_rx.sv ====
`default_nettype none

module uart_word_rx import board_pkg::*; (
    input  wire logic   sys_clk,
    input  wire logic   rst_n,
    input  wire logic   rxd,
    output logic        word_valid,
    output board_word_t word
);

    logic                  rxd_meta, rxd_sync;
    uart_state_t           state;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [2:0]            bit_cnt;
    logic [1:0]            byte_cnt;
    logic [7:0]            rx_byte;
    logic                  half_done;
    logic                  bit_done;
    logic                  stop_ok;

    assign half_done = baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);
    assign bit_done  = baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1);
    assign stop_ok   = (state == UART_STOP) && bit_done && rxd_sync;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rxd_meta   <= 1'b1;
            rxd_sync   <= 1'b1;
            state      <= UART_IDLE;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            word_valid <= 1'b0;
        end else begin
            rxd_meta   <= rxd;
            rxd_sync   <= rxd_meta;
            word_valid <= 1'b0;
            case (state)
                UART_IDLE: begin
                    baud_cnt <= '0;
                    if (!rxd_sync) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    // glitch check at mid start bit
                    if (half_done) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rxd_sync ? UART_IDLE : UART_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (bit_done) begin
                        state <= UART_IDLE;
                        if (!rxd_sync) begin
                            // framing error drops the partial word
                            byte_cnt <= '0;
                        end else if (byte_cnt == 2'd2) begin
                            byte_cnt   <= '0;
                            word_valid <= 1'b1;
                        end else begin
                            byte_cnt <= byte_cnt + 2'd1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == UART_DATA && bit_done) begin
            rx_byte <= {rxd_sync, rx_byte[7:1]};
        end
        // first byte ends up in bits 7:0
        if (stop_ok) begin
            word <= {rx_byte, word[23:8]};
        end
    end

endmodule

`default_nettype wire

// ==== hw/interrupt_merger.sv ====
`default_nettype none

module interrupt_merger import board_pkg::*; (
    input  wire logic        sys_clk,
    input  wire logic        rst_n,
    input  wire logic        key_valid,
    input  wire key_event_t  key_event,
    input  wire logic        word_valid,
    input  wire board_word_t word,
    output logic             irq_valid,
    output irq_code_t        irq_code,
    output seg_t             hex0,
    output seg_t             hex1,
    output seg_t             hex2,
    output seg_t             hex3,
    output seg_t             hex4,
    output seg_t             hex5
);

    logic        pend_valid;
    key_event_t  pend_event;
    board_word_t disp_word;

    function automatic irq_code_t key_to_irq(input key_event_t ev);
        irq_code_t code;
        case (ev[1:0])
            DIR_UP:   code = IRQ_UP;
            DIR_DOWN: code = IRQ_DOWN;
            DIR_LEFT: code = IRQ_LEFT;
            default:  code = IRQ_RIGHT;
        endcase
        // fire wins over any direction
        if (ev[2]) begin
            code = IRQ_FIRE;
        end
        return code;
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            irq_valid  <= 1'b0;
            pend_valid <= 1'b0;
            disp_word  <= '0;
        end else begin
            irq_valid <= word_valid | pend_valid | key_valid;
            if (word_valid) begin
                disp_word <= word;
                // a colliding key waits one cycle
                if (key_valid) begin
                    pend_valid <= 1'b1;
                end
            end else if (pend_valid) begin
                pend_valid <= key_valid;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (word_valid) begin
            irq_code <= irq_code_t'(word);
            if (key_valid) begin
                pend_event <= key_event;
            end
        end else if (pend_valid) begin
            irq_code   <= key_to_irq(pend_event);
            pend_event <= key_event;
        end else if (key_valid) begin
            irq_code <= key_to_irq(key_event);
        end
    end

    // hex0 is the low nibble
    assign hex0 = SEG_PATTERNS[disp_word[3:0]];
    assign hex1 = SEG_PATTERNS[disp_word[7:4]];
    assign hex2 = SEG_PATTERNS[disp_word[11:8]];
    assign hex3 = SEG_PATTERNS[disp_word[15:12]];
    assign hex4 = SEG_PATTERNS[disp_word[19:16]];
    assign hex5 = SEG_PATTERNS[disp_word[23:20]];

endmodule

`default_nettype wire

// ==== hw/board_io_top.sv ====
`default_nettype none

module board_io_top import board_pkg::*; (
    input  wire logic sys_clk,
    input  wire logic rst_n,
    input  wire logic ps2_clk,
    input  wire logic ps2_dat,
    input  wire logic rxd,
    output logic      irq_valid,
    output irq_code_t irq_code,
    output seg_t      hex0,
    output seg_t      hex1,
    output seg_t      hex2,
    output seg_t      hex3,
    output seg_t      hex4,
    output seg_t      hex5
);

    logic        key_valid;
    key_event_t  key_event;
    logic        word_valid;
    board_word_t word;

    ps2_key_decoder u_ps2_key_decoder (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .key_valid (key_valid),
        .key_event (key_event)
    );

    // link from the other board
    uart_word_rx u_uart_word_rx (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .rxd        (rxd),
        .word_valid (word_valid),
        .word       (word)
    );

    interrupt_merger u_interrupt_merger (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .key_valid  (key_valid),
        .key_event  (key_event),
        .word_valid (word_valid),
        .word       (word),
        .irq_valid  (irq_valid),
        .irq_code   (irq_code),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .hex4       (hex4),
        .hex5       (hex5)
    );

endmodule

`default_nettype wire

// ==== verification/board_io_tb.sv ====
`default_nettype none

module board_io_tb
    import board_pkg::*;
();

    localparam int PS2_HALF    = 8;
    // key frame starts this late so both stop bits end together
    localparam int KEY_OFFSET  = 303;
    // one full serial word plus the worst idle gap and some slack
    localparam int TEST_CYCLES = 700;

    logic        sys_clk;
    logic        rst_n;
    logic        ps2_clk;
    logic        ps2_dat;
    logic        rxd;
    logic        irq_valid;
    irq_code_t   irq_code;
    seg_t        hex [6];

    byte         kinds [$];
    logic [31:0] values [$];
    logic [31:0] codes [$];
    irq_code_t   exp_q [$];
    irq_code_t   got_q [$];
    logic [31:0] rng = 32'd77131;
    int          cycles = 0;
    int          limit = 1000;
    int          coincide_cnt = 0;
    int          errors = 0;

    board_io_top i_dut (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .rxd       (rxd),
        .irq_valid (irq_valid),
        .irq_code  (irq_code),
        .hex0      (hex[0]),
        .hex1      (hex[1]),
        .hex2      (hex[2]),
        .hex3      (hex[3]),
        .hex4      (hex[4]),
        .hex5      (hex[5])
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            stop_run($sformatf("timeout, run still going after %0d cycles", cycles));
        end
    end

    // interrupt monitor
    always @(negedge sys_clk) begin
        if (irq_valid) begin
            got_q.push_back(irq_code);
        end
        if (i_dut.key_valid && i_dut.word_valid) begin
            coincide_cnt++;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic report_failure(input string msg);
        stop_run($sformatf("FAIL @%0t: %s", $time, msg));
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] value;
        logic [31:0] code;
        fd = $fopen("verification/board_io_tests.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open verification/board_io_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 2 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", kind, value, code);
                    if (n == 3) begin
                        kinds.push_back(kind);
                        values.push_back(value);
                        codes.push_back(code);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_ps2_frame(input scan_code_t data, input logic bad_parity);
        logic [10:0] frame;
        // stop, odd parity, data, start
        frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
        for (int b = 0; b < 11; b++) begin
            ps2_dat = frame[b];
            repeat (PS2_HALF) @(negedge sys_clk);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge sys_clk);
            ps2_clk = 1'b1;
        end
    endtask

    task automatic send_serial_byte(input logic [7:0] data, input logic stop);
        logic [9:0] bits;
        bits = {stop, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            rxd = bits[b];
            repeat (CLKS_PER_BIT) @(negedge sys_clk);
        end
    endtask

    task automatic send_serial_word(input board_word_t w, input logic cut);
        send_serial_byte(w[7:0], 1'b1);
        if (cut) begin
            // second byte ends in a 0 stop bit and the third is never sent
            send_serial_byte(w[15:8], 1'b0);
        end else begin
            send_serial_byte(w[15:8], 1'b1);
            send_serial_byte(w[23:16], 1'b1);
        end
        rxd = 1'b1;
    endtask

    task automatic check_irqs();
        irq_code_t got;
        irq_code_t want;
        int        gap;
        while (got_q.size() < exp_q.size()) begin
            @(negedge sys_clk);
        end
        // quiet gap catches late or extra pulses
        rng = xorshift(rng);
        gap = 20 + int'(rng % 40);
        repeat (gap) @(negedge sys_clk);
        assert (got_q.size() == exp_q.size())
            else report_failure($sformatf("%0d interrupts, expected %0d",
                                          got_q.size(), exp_q.size()));
        while (exp_q.size() > 0) begin
            got  = got_q.pop_front();
            want = exp_q.pop_front();
            assert (got == want)
                else report_failure($sformatf("irq_code %h, expected %h", got, want));
        end
    endtask

    task automatic check_digits(input board_word_t w);
        for (int d = 0; d < 6; d++) begin
            assert (hex[d] == SEG_PATTERNS[w[4*d +: 4]])
                else report_failure($sformatf("hex%0d is %b, expected digit %h",
                                              d, hex[d], w[4*d +: 4]));
        end
    endtask

    initial begin
        int          i;
        int          base_cnt;
        board_word_t disp_exp;
        rst_n   = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        rxd     = 1'b1;
        load_tests();
        if (kinds.size() == 0) begin
            stop_run("no tests found in verification/board_io_tests.txt");
        end
        limit = (kinds.size() + 2) * TEST_CYCLES;
        repeat (4) @(negedge sys_clk);
        rst_n = 1'b1;
        @(negedge sys_clk);
        assert (irq_valid == 1'b0) else report_failure("irq_valid high after reset");
        disp_exp = '0;
        check_digits(disp_exp);
        i = 0;
        while (i < kinds.size()) begin
            if (kinds[i] == "C") begin
                // key frame on this line and board word on the next
                base_cnt = coincide_cnt;
                fork
                    send_serial_word(values[i + 1][23:0], 1'b0);
                    begin
                        repeat (KEY_OFFSET) @(negedge sys_clk);
                        send_ps2_frame(values[i][7:0], 1'b0);
                    end
                join
                exp_q.push_back(codes[i + 1]);
                exp_q.push_back(codes[i]);
                check_irqs();
                assert (coincide_cnt > base_cnt)
                    else stop_run("key and board events did not arrive in the same cycle");
                disp_exp = values[i + 1][23:0];
                check_digits(disp_exp);
                i += 2;
            end else begin
                if (codes[i] != 0) begin
                    exp_q.push_back(codes[i]);
                end
                case (kinds[i])
                    "K": send_ps2_frame(values[i][7:0], 1'b0);
                    "P": send_ps2_frame(values[i][7:0], 1'b1);
                    "U": send_serial_word(values[i][23:0], 1'b0);
                    "S": send_serial_word(values[i][23:0], 1'b1);
                    default: stop_run($sformatf("unknown test kind %c", kinds[i]));
                endcase
                check_irqs();
                if (kinds[i] == "U") begin
                    disp_exp = values[i][23:0];
                end
                if (kinds[i] == "U" || kinds[i] == "S") begin
                    check_digits(disp_exp);
                end
                i++;
            end
        end
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/board_io_tests.txt ====
# kind value expected_code, hex; expected code 0 means no interrupt
# K key frame, P key frame with bad parity, U serial word, S word cut by bad stop bit
# C key frame that ends together with the serial word on the next line
K 1D 00000067
K F0 0
K 1D 0
K 1B 00000068
K F0 0
K 1B 0
K 1C 00000066
K F0 0
K 1C 0
K 23 00000069
K F0 0
K 23 0
K 29 0000006A
K F0 0
K 29 0
K 15 0
P 1D 0
K 1B 00000068
U 123456 00123456
U A5C30F 00A5C30F
S 777777 0
U FEDCBA 00FEDCBA
C 23 00000069
U 0BEEF1 000BEEF1
K 29 0000006A

// ==== compile.f ====
hw/board_pkg.sv
hw/ps2_key_decoder.sv
hw/uart_word_rx.sv
hw/interrupt_merger.sv
hw/board_io_top.sv
verification/board_io_tb.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing -Wno-fatal
TOP      := board_io_tb
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log
TESTS    := verification/board_io_tests.txt

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BINARY   := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BINARY) $(TESTS)
	./$(BINARY) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
